/* verilog.f */
source/ifu_pkg.sv
source/ifu_pc_gen.sv
source/ifu_imem.sv
source/ifu_bpu.sv
source/ifu_pipe.sv
source/ifu_top.sv
verif/ifu_tb.sv

/* verif/ifu_tb.sv */
// ****************************************
// directed testbench for the fetch unit
// loads a program in reset, then checks fetch order and prediction
// ****************************************

`timescale 1ns/1ns

module ifu_tb;

    import ifu_pkg::*;

    localparam int    DEPTH      = 256; // dut default imem size
    localparam addr_t START_PC   = '0;  // dut default reset pc
    localparam int    FIRST_WAIT = 4;   // bubble cycles after reset release

    logic  clk;
    logic  rst_n_i;
    logic  stall_i;
    logic  flush_i;
    addr_t redirect_pc_i;
    logic  imem_we_i;
    addr_t imem_waddr_i;
    inst_t imem_wdata_i;
    inst_t inst_o;
    addr_t inst_addr_o;
    logic  is_pred_branch_o;
    logic  inst_valid_o;

    inst_t       model_mem [DEPTH]; // tb image of imem
    addr_t       exp_pc;            // next address decode should see
    logic [31:0] lfsr_state;

    inst_t held_inst;  // outputs captured at stall start
    addr_t held_addr;
    logic  held_pred;
    logic  held_valid;

    ifu_top dut_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .stall_i         (stall_i),
        .flush_i         (flush_i),
        .redirect_pc_i   (redirect_pc_i),
        .imem_we_i       (imem_we_i),
        .imem_waddr_i    (imem_waddr_i),
        .imem_wdata_i    (imem_wdata_i),
        .inst_o          (inst_o),
        .inst_addr_o     (inst_addr_o),
        .is_pred_branch_o(is_pred_branch_o),
        .inst_valid_o    (inst_valid_o)
    );

    always #4 clk = ~clk; // 8 ns period

    // fibonacci lfsr, taps 32 22 2 1
    // one step per returned bit, msb first
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic int unsigned word_index(input addr_t a);
        return (a >> 2) % DEPTH; // wraps like the dut memory
    endfunction

    // op-imm with random fields above the opcode, never a branch
    function automatic inst_t filler_word();
        logic [31:0] r;
        r = take_bits(25);
        return {r[24:0], OPC_OP_IMM};
    endfunction

    function automatic inst_t encode_jal(input int offset);
        logic [20:0] i;
        i = offset[20:0];
        return {i[20], i[10:1], i[11], i[19:12], 5'd1, OPC_JAL}; // rd = ra
    endfunction

    function automatic inst_t encode_branch(input int offset);
        logic [12:0] i;
        logic [31:0] r;
        i = offset[12:0];
        r = take_bits(13); // rs1, rs2, funct3
        return {i[12], i[10:5], r[12:8], r[7:3], r[2:0], i[4:1], i[11], OPC_BRANCH};
    endfunction

    // jal always taken and a branch only when its offset is negative
    function automatic logic model_taken(input inst_t w);
        return (w[6:0] == OPC_JAL) || ((w[6:0] == OPC_BRANCH) && w[31]);
    endfunction

    function automatic addr_t model_target(input addr_t pc, input inst_t w);
        logic signed [20:0] j_off;
        logic signed [12:0] b_off;
        int                 ofs;
        j_off = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        b_off = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        if (w[6:0] == OPC_JAL) begin
            ofs = int'(j_off); // sign extends
        end else begin
            ofs = int'(b_off);
        end
        return pc + addr_t'(ofs);
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        assert (act === exp) else begin
            $display("MISMATCH at %0t ns: %s expected %h got %h", $time, name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "output check failed");
        end
    endtask

    task automatic fill_filler();
        for (int i = 0; i < DEPTH; i++) begin
            model_mem[i] = filler_word();
        end
    endtask

    task automatic check_bubble();
        check_word("inst_valid_o", 32'd0, {31'd0, inst_valid_o});
        check_word("inst_o", INST_NOP, inst_o);
        check_word("inst_addr_o", 32'd0, inst_addr_o);
        check_word("is_pred_branch_o", 32'd0, {31'd0, is_pred_branch_o});
    endtask

    task automatic check_reset_outputs();
        check_word("inst_valid_o", 32'd0, {31'd0, inst_valid_o});
        check_word("is_pred_branch_o", 32'd0, {31'd0, is_pred_branch_o});
        check_word("inst_o", 32'd0, inst_o);
    endtask

    // whole image written through the load port, core held in reset
    task automatic load_and_reset();
        @(posedge clk);
        rst_n_i <= 1'b0;
        stall_i <= 1'b0;
        flush_i <= 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            imem_we_i    <= 1'b1;
            imem_waddr_i <= addr_t'(i * 4);
            imem_wdata_i <= model_mem[i];
            @(posedge clk);
        end
        imem_we_i <= 1'b0;
        repeat (2) begin // reset 2 more cycles
            @(negedge clk);
            check_reset_outputs();
            @(posedge clk);
        end
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_reset_outputs(); // release edge still saw reset
        exp_pc = START_PC;
    endtask

    // next valid output must be exp_pc and its model word
    task automatic expect_fetch(input int max_wait);
        int    waited;
        inst_t exp_word;
        logic  exp_pred;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while ((inst_valid_o !== 1'b1) && (waited < max_wait));
        if (inst_valid_o !== 1'b1) begin
            $display("timeout: no valid instruction after %0d cycles, expected address %h",
                     max_wait, exp_pc);
            $display("TESTS FAILED");
            $fatal(1, "fetch timeout");
        end
        exp_word = model_mem[word_index(exp_pc)];
        exp_pred = model_taken(exp_word);
        check_word("inst_addr_o", exp_pc, inst_addr_o);
        check_word("inst_o", exp_word, inst_o);
        check_word("is_pred_branch_o", {31'd0, exp_pred}, {31'd0, is_pred_branch_o});
        exp_pc = exp_pred ? model_target(exp_pc, exp_word) : exp_pc + 32'd4;
    endtask

    task automatic take_snapshot();
        held_inst  = inst_o;
        held_addr  = inst_addr_o;
        held_pred  = is_pred_branch_o;
        held_valid = inst_valid_o;
    endtask

    task automatic check_held();
        check_word("inst_o", held_inst, inst_o);
        check_word("inst_addr_o", held_addr, inst_addr_o);
        check_word("is_pred_branch_o", {31'd0, held_pred}, {31'd0, is_pred_branch_o});
        check_word("inst_valid_o", {31'd0, held_valid}, {31'd0, inst_valid_o});
    endtask

    task automatic test_reset_state();
        fill_filler();
        load_and_reset();
        expect_fetch(FIRST_WAIT);
        check_word("inst_addr_o", START_PC, inst_addr_o); // first fetch at reset pc
    endtask

    task automatic test_straight_line();
        fill_filler();
        load_and_reset();
        expect_fetch(FIRST_WAIT);
        repeat (24) begin
            expect_fetch(1); // back to back, no gaps
            check_word("is_pred_branch_o", 32'd0, {31'd0, is_pred_branch_o});
        end
    endtask

    task automatic test_static_prediction();
        fill_filler();
        model_mem[2]  = encode_jal(24);     // 8 -> 32
        model_mem[8]  = encode_branch(16);  // forward, falls through
        model_mem[10] = encode_branch(-8);  // 40 -> 32
        load_and_reset();
        expect_fetch(FIRST_WAIT);
        expect_fetch(1);
        expect_fetch(1); // jal
        check_word("is_pred_branch_o", 32'd1, {31'd0, is_pred_branch_o});
        expect_fetch(1);
        check_word("inst_addr_o", 32'd32, inst_addr_o);
        check_word("is_pred_branch_o", 32'd0, {31'd0, is_pred_branch_o});
        expect_fetch(1);
        check_word("inst_addr_o", 32'd36, inst_addr_o);
        expect_fetch(1); // backward branch
        check_word("is_pred_branch_o", 32'd1, {31'd0, is_pred_branch_o});
        expect_fetch(1);
        check_word("inst_addr_o", 32'd32, inst_addr_o);
    endtask

    task automatic test_stall();
        int n;
        fill_filler();
        load_and_reset();
        expect_fetch(FIRST_WAIT);
        repeat (3) expect_fetch(1);
        n = 1 + int'(take_bits(3));
        @(posedge clk);
        stall_i <= 1'b1;
        expect_fetch(1); // in flight before the stall
        take_snapshot();
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            if (i == n - 1) begin
                stall_i <= 1'b0;
            end
            @(negedge clk);
            check_held();
        end
        repeat (4) expect_fetch(1); // resumes where it left off
    endtask

    task automatic test_flush();
        addr_t r;
        fill_filler();
        load_and_reset();
        expect_fetch(FIRST_WAIT);
        repeat (2) expect_fetch(1);
        r = take_bits(8) << 2;
        @(posedge clk);
        flush_i       <= 1'b1;
        redirect_pc_i <= r;
        expect_fetch(1);
        @(posedge clk);
        flush_i <= 1'b0;
        @(negedge clk);
        check_bubble();
        exp_pc = r;
        repeat (3) expect_fetch(1);
    endtask

    task automatic test_flush_in_stall();
        addr_t r;
        int    n;
        fill_filler();
        load_and_reset();
        expect_fetch(FIRST_WAIT);
        repeat (2) expect_fetch(1);
        r = take_bits(8) << 2;
        n = int'(take_bits(2));
        @(posedge clk);
        stall_i <= 1'b1;
        expect_fetch(1);
        take_snapshot();
        @(posedge clk);
        flush_i       <= 1'b1;
        redirect_pc_i <= r;
        @(negedge clk);
        check_held();
        @(posedge clk);
        flush_i <= 1'b0; // pc redirects here, pipe holds
        @(negedge clk);
        check_held();
        repeat (n) begin
            @(posedge clk);
            @(negedge clk);
            check_held();
        end
        @(posedge clk);
        stall_i <= 1'b0;
        @(negedge clk);
        check_held();
        exp_pc = r;
        repeat (3) expect_fetch(1);
    endtask

    initial begin
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        stall_i       = 1'b0;
        flush_i       = 1'b0;
        redirect_pc_i = '0;
        imem_we_i     = 1'b0;
        imem_waddr_i  = '0;
        imem_wdata_i  = '0;
        lfsr_state    = 32'h3bdd;
        exp_pc        = START_PC;

        test_reset_state();
        test_straight_line();
        test_static_prediction();
        test_stall();
        test_flush();
        test_flush_in_stall();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* source/ifu_top.sv */
// ****************************************
// fetch unit top for the rv32i core
// execute drives stall and flush, decode takes the pipe outputs
// ****************************************

`timescale 1ns/1ns

module ifu_top #(
    parameter ifu_pkg::addr_t RESET_PC   = '0,  // reset fetch address
    parameter int unsigned    IMEM_DEPTH = 256  // imem words
) (
    input  logic           clk,
    input  logic           rst_n_i,

    // back end control
    input  logic           stall_i,       // level, freezes pc and pipe
    input  logic           flush_i,       // pulse with redirect_pc_i
    input  ifu_pkg::addr_t redirect_pc_i, // resolved target from execute

    // program load
    input  logic           imem_we_i,
    input  ifu_pkg::addr_t imem_waddr_i,  // byte address
    input  ifu_pkg::inst_t imem_wdata_i,

    // to decode
    output ifu_pkg::inst_t inst_o,
    output ifu_pkg::addr_t inst_addr_o,
    output logic           is_pred_branch_o,
    output logic           inst_valid_o
);

    import ifu_pkg::*;

    addr_t pc;          // fetch address
    logic  fetch_valid; // post-reset fetch level
    inst_t fetch_inst;  // word at pc
    logic  pred_taken;  // bpu redirect
    addr_t pred_target;

    ifu_pc_gen #(
        .RESET_PC(RESET_PC)
    ) u_pc_gen (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .redirect_pc_i(redirect_pc_i),
        .pred_taken_i (pred_taken),
        .pred_target_i(pred_target),
        .pc_o         (pc),
        .fetch_valid_o(fetch_valid)
    );

    ifu_imem #(
        .IMEM_DEPTH(IMEM_DEPTH)
    ) u_imem (
        .clk    (clk),
        .pc_i   (pc),
        .inst_o (fetch_inst),
        .we_i   (imem_we_i),
        .waddr_i(imem_waddr_i),
        .wdata_i(imem_wdata_i)
    );

    // same-cycle guess on the word just read
    ifu_bpu u_bpu (
        .pc_i         (pc),
        .inst_i       (fetch_inst),
        .pred_taken_o (pred_taken),
        .pred_target_o(pred_target)
    );

    ifu_pipe u_pipe (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .inst_i          (fetch_inst),
        .inst_addr_i     (pc),
        .is_pred_branch_i(pred_taken),  // flag rides with the inst
        .flush_flag_i    (flush_i),
        .inst_valid_i    (fetch_valid),
        .stall_i         (stall_i),
        .inst_o          (inst_o),
        .inst_addr_o     (inst_addr_o),
        .is_pred_branch_o(is_pred_branch_o),
        .inst_valid_o    (inst_valid_o)
    );

endmodule

/* source/ifu_pipe.sv */
// ****************************************
// if/id pipeline register between fetch and decode
// holds on stall, inserts a nop bubble on flush or invalid fetch
// ****************************************

`timescale 1ns/1ns

module ifu_pipe (
    input  logic           clk,
    input  logic           rst_n_i,

    input  ifu_pkg::inst_t inst_i,            // fetched word
    input  ifu_pkg::addr_t inst_addr_i,       // its address
    input  logic           is_pred_branch_i,  // bpu guessed taken

    input  logic           flush_flag_i,      // kill the incoming fetch
    input  logic           inst_valid_i,      // fetch valid level
    input  logic           stall_i,           // hold all outputs

    output ifu_pkg::inst_t inst_o,            // to decode
    output ifu_pkg::addr_t inst_addr_o,
    output logic           is_pred_branch_o,  // to decode and execute
    output logic           inst_valid_o
);

    import ifu_pkg::*;

    inst_t inst_q;
    addr_t inst_addr_q;
    logic  pred_q;
    logic  valid_q;

    inst_t inst_d;      // word or bubble
    addr_t inst_addr_d;
    logic  pred_d;
    logic  valid_d;

    // bubble when flushing or nothing was fetched
    assign inst_d = (flush_flag_i || !inst_valid_i) ? INST_NOP : inst_i;

    // flush zeroes address, flag and valid
    assign inst_addr_d = flush_flag_i ? '0 : inst_addr_i;
    assign valid_d     = !flush_flag_i && inst_valid_i;
    // a bubble never carries a prediction
    assign pred_d      = !flush_flag_i && inst_valid_i && is_pred_branch_i;

    // load on every non-stalled edge
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inst_q      <= '0;
            inst_addr_q <= '0;
            pred_q      <= 1'b0;
            valid_q     <= 1'b0;
        end else if (!stall_i) begin
            inst_q      <= inst_d;
            inst_addr_q <= inst_addr_d;
            pred_q      <= pred_d;
            valid_q     <= valid_d;
        end
    end

    assign inst_o           = inst_q;
    assign inst_addr_o      = inst_addr_q;
    assign is_pred_branch_o = pred_q;
    assign inst_valid_o     = valid_q;

    // once loaded out of reset a dead slot always holds a nop
    // reset zeros before the first load are excluded
    a_invalid_is_nop: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        ($past(rst_n_i && !stall_i) && !inst_valid_o) |-> (inst_o == INST_NOP)
    ) else $error("ifu_pipe: invalid slot carries %h", inst_o);

endmodule

/* source/ifu_bpu.sv */
// ****************************************
// static branch predictor, decodes the fetched word
// jal always taken, conditional branches taken only when backward
// ****************************************

`timescale 1ns/1ns

module ifu_bpu (
    input  ifu_pkg::addr_t pc_i,          // address of the fetched word
    input  ifu_pkg::inst_t inst_i,        // word straight out of imem

    output logic           pred_taken_o,  // redirect fetch to target
    output ifu_pkg::addr_t pred_target_o  // pc plus selected immediate
);

    import ifu_pkg::*;

    opcode_t opcode;      // inst[6:0]
    addr_t   imm_j;       // j-type offset, sign extended
    addr_t   imm_b;       // b-type offset, sign extended
    addr_t   imm_sel;     // offset used for the target
    logic    is_jal;
    logic    is_branch;
    logic    is_backward; // offset sign bit

    assign opcode = inst_i[6:0];

    // j-immediate
    // imm[20|10:1|11|19:12] sits in inst[31:12]
    assign imm_j = {
        {12{inst_i[31]}},   // sign
        inst_i[19:12],      // imm[19:12]
        inst_i[20],         // imm[11]
        inst_i[30:21],      // imm[10:1]
        1'b0                // always even
    };

    // b-immediate
    // imm[12|10:5] in inst[31:25], imm[4:1|11] in inst[11:7]
    assign imm_b = {
        {20{inst_i[31]}},   // sign
        inst_i[7],          // imm[11]
        inst_i[30:25],      // imm[10:5]
        inst_i[11:8],       // imm[4:1]
        1'b0
    };

    // opcode decode, funct3 does not matter for the guess
    assign is_jal    = (opcode == OPC_JAL);
    assign is_branch = (opcode == OPC_BRANCH);

    // both immediates keep the sign in inst[31]
    assign is_backward = inst_i[31];

    // btfn rule
    // loops close backward so those are taken
    assign pred_taken_o = is_jal | (is_branch & is_backward);

    // target adder is shared between jal and branch
    assign imm_sel       = is_jal ? imm_j : imm_b;
    assign pred_target_o = pc_i + imm_sel; // don't care when not taken

    // no clock here so a deferred check
    // alignment depends on the program having no compressed offsets
    always_comb begin
        if (pred_taken_o === 1'b1) begin
            a_target_aligned: assert #0 (pred_target_o[1:0] == 2'b00)
                else $error("ifu_bpu: misaligned target %h from pc %h",
                            pred_target_o, pc_i);
        end
    end

endmodule

/* source/ifu_imem.sv */
// ****************************************
// word-addressed instruction memory, async read
// loaded through the write port while the core sits in reset
// ****************************************

`timescale 1ns/1ns

module ifu_imem #(
    parameter int unsigned IMEM_DEPTH = 256 // words, power of two
) (
    input  logic           clk,

    // fetch side
    input  ifu_pkg::addr_t pc_i,    // byte address from pc gen
    output ifu_pkg::inst_t inst_o,  // word at pc, same cycle

    // load port
    input  logic           we_i,    // write strobe
    input  ifu_pkg::addr_t waddr_i, // byte address, low two bits ignored
    input  ifu_pkg::inst_t wdata_i  // word to store
);

    import ifu_pkg::*;

    // index width for the word array
    localparam int unsigned IDX_W = $clog2(IMEM_DEPTH);

    inst_t              mem [IMEM_DEPTH]; // program storage
    logic [IDX_W-1:0]   rd_idx;           // word index of fetch pc
    logic [IDX_W-1:0]   wr_idx;           // word index of load address

    // drop byte offset, wrap modulo depth
    assign rd_idx = pc_i[IDX_W+1:2];
    assign wr_idx = waddr_i[IDX_W+1:2];

    // synchronous write on the load port
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_idx] <= wdata_i;
        end
    end

    // combinational read
    // predictor and pipe see the word in the fetch cycle
    assign inst_o = mem[rd_idx];

    // an x address would scribble an unknown location
    // and the later fetch from there would look fine
    a_waddr_known: assert property (
        @(posedge clk)
        we_i |-> !$isunknown(waddr_i)
    ) else $error("ifu_imem: write with unknown address %h", waddr_i);

endmodule

/* source/ifu_pc_gen.sv */
// ****************************************
// fetch program counter with next-pc priority
// drives the imem read address and fetch valid level
// ****************************************

`timescale 1ns/1ns

module ifu_pc_gen #(
    parameter ifu_pkg::addr_t RESET_PC = '0 // first fetch address out of reset
) (
    input  logic           clk,
    input  logic           rst_n_i,

    input  logic           stall_i,        // hold pc, from execute
    input  logic           flush_i,        // one-cycle redirect pulse
    input  ifu_pkg::addr_t redirect_pc_i,  // valid with flush_i

    input  logic           pred_taken_i,   // static prediction from bpu
    input  ifu_pkg::addr_t pred_target_i,  // target when predicted taken

    output ifu_pkg::addr_t pc_o,           // current fetch address
    output logic           fetch_valid_o   // high from first clock after reset
);

    import ifu_pkg::*;

    addr_t pc_q;          // fetch pc register
    addr_t pc_next;       // selected next pc
    addr_t pc_seq;        // sequential successor
    logic  fetch_valid_q; // set once after reset release

    assign pc_seq = pc_q + addr_t'(4); // no compressed insts, always +4

    // next pc selection
    // flush beats everything, even a stall
    // before fetch_valid rises the pc holds so RESET_PC is not skipped
    always_comb begin
        if (flush_i) begin
            pc_next = redirect_pc_i;      // execute redirect
        end else if (stall_i || !fetch_valid_q) begin
            pc_next = pc_q;               // hold
        end else if (pred_taken_i) begin
            pc_next = pred_target_i;      // jal or backward branch
        end else begin
            pc_next = pc_seq;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q          <= RESET_PC;
            fetch_valid_q <= 1'b0;
        end else begin
            pc_q          <= pc_next;
            fetch_valid_q <= 1'b1; // sticky after first edge
        end
    end

    assign pc_o          = pc_q;
    assign fetch_valid_o = fetch_valid_q;

    // pc gets its value from redirect, bpu target or +4
    // a misaligned source anywhere upstream lands here
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        pc_o[1:0] == 2'b00
    ) else $error("ifu_pc_gen: misaligned pc %h", pc_o);

endmodule

/* source/ifu_pkg.sv */
// ****************************************
// shared widths, types and rv32 encodings for the fetch unit
// compile first, modules import what they need
// ****************************************

package ifu_pkg;

    // architectural width of rv32i
    localparam int XLEN = 32;

    // one fetched instruction word
    typedef logic [XLEN-1:0] inst_t;

    // byte address into instruction space
    typedef logic [XLEN-1:0] addr_t;

    // major opcode field, inst[6:0]
    typedef logic [6:0] opcode_t;

    // addi x0,x0,0
    // used as the bubble on invalid fetch or flush
    localparam inst_t INST_NOP = 32'h0000_0013;

    // major opcodes the predictor looks at
    localparam opcode_t OPC_JAL    = 7'b110_1111; // unconditional jump, pc-relative
    localparam opcode_t OPC_BRANCH = 7'b110_0011; // beq/bne/blt/bge/bltu/bgeu

    // register-immediate alu ops
    // never a branch, handy as filler in test programs
    localparam opcode_t OPC_OP_IMM = 7'b001_0011;

endpackage
